//--- mips_pkg.sv
package mips_pkg;

    // basic word and register types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  rwen_t;

    // one instruction word, seen either as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            logic [15:0] imm;
        } i;
    } instr_u;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_ADDU    = 6'h21;

    // boot vector, lives in kseg1
    localparam word_t RESET_PC = 32'hbfc0_0000;

endpackage

//--- handshake.sv
`timescale 1ns/1ps

module handshake (
    input  logic clk,
    input  logic reset,
    input  logic cpu_req,
    output logic req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic done
);
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ADDR = 2'd1;
    localparam logic [1:0] S_DATA = 2'd2;

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (cpu_req) state <= S_ADDR;
                S_ADDR: if (addr_ok) state <= S_DATA;
                S_DATA: if (data_ok) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // request only while the address phase is open
    assign req  = (state == S_ADDR);
    assign done = (state == S_DATA) && data_ok;

    // the core keeps its request level until done
    a_cpu_req_held: assert property (@(posedge clk) disable iff (reset)
        cpu_req && !done |=> cpu_req);

    // responses only for the transaction in flight
    a_data_ok_in_phase: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> state == S_DATA);

endmodule

//--- mips_core.sv
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output logic      inst_en,
    output word_t     inst_vaddr,
    input  logic      inst_done,
    input  word_t     inst_rdata,
    output logic      data_en,
    output logic      data_wt,
    output word_t     data_vaddr,
    output word_t     data_wdata,
    input  logic      data_done,
    input  word_t     data_rdata,
    output logic      wb_valid,
    output word_t     wb_pc,
    output reg_addr_t wb_wnum,
    output word_t     wb_wdata
);
    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_EXEC  = 2'd1;
    localparam logic [1:0] S_MEM   = 2'd2;
    localparam logic [1:0] S_WB    = 2'd3;

    logic [1:0] state;
    word_t      pc;
    word_t      npc;
    instr_u     ir;
    word_t      rf [32];

    word_t      rs_val;
    word_t      rt_val;
    word_t      simm;
    word_t      alu_res;
    word_t      res;
    reg_addr_t  wnum;
    reg_addr_t  wnum_q;
    logic       is_addu, is_addiu, is_lui, is_lw, is_sw, is_beq;

    // register reads, r0 is hardwired
    assign rs_val = (ir.i.rs == '0) ? '0 : rf[ir.i.rs];
    assign rt_val = (ir.i.rt == '0) ? '0 : rf[ir.i.rt];
    assign simm   = {{16{ir.i.imm[15]}}, ir.i.imm};

    // decode
    assign is_addu  = (ir.r.opcode == OP_SPECIAL) && (ir.r.funct == FN_ADDU);
    assign is_addiu = (ir.i.opcode == OP_ADDIU);
    assign is_lui   = (ir.i.opcode == OP_LUI);
    assign is_lw    = (ir.i.opcode == OP_LW);
    assign is_sw    = (ir.i.opcode == OP_SW);
    assign is_beq   = (ir.i.opcode == OP_BEQ);

    always_comb begin
        alu_res = '0;
        wnum    = '0;
        if (is_addu) begin
            alu_res = rs_val + rt_val;
            wnum    = ir.r.rd;
        end else if (is_addiu) begin
            alu_res = rs_val + simm;
            wnum    = ir.i.rt;
        end else if (is_lui) begin
            alu_res = {ir.i.imm, 16'h0000};
            wnum    = ir.i.rt;
        end else if (is_lw) begin
            // effective address now, load data replaces it later
            alu_res = rs_val + simm;
            wnum    = ir.i.rt;
        end else if (is_sw) begin
            alu_res = rs_val + simm;
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
            pc    <= RESET_PC;
        end else begin
            case (state)
                S_FETCH: if (inst_done) state <= S_EXEC;
                S_EXEC:  state <= (is_lw || is_sw) ? S_MEM : S_WB;
                S_MEM:   if (data_done) state <= S_WB;
                S_WB: begin
                    pc    <= npc;
                    state <= S_FETCH;
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // instruction word and per-instruction results
    always_ff @(posedge clk) begin
        if (state == S_FETCH && inst_done) begin
            ir <= inst_rdata;
        end
        if (state == S_EXEC) begin
            res    <= alu_res;
            wnum_q <= wnum;
            // no delay slot, target is relative to pc + 4
            if (is_beq && rs_val == rt_val) begin
                npc <= pc + 32'd4 + {simm[29:0], 2'b00};
            end else begin
                npc <= pc + 32'd4;
            end
        end
        if (state == S_MEM && data_done && is_lw) begin
            res <= data_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (state == S_WB && wnum_q != '0) begin
            rf[wnum_q] <= res;
        end
    end

    assign inst_en    = (state == S_FETCH);
    assign inst_vaddr = pc;

    // address sits in res for the whole memory phase
    assign data_en    = (state == S_MEM);
    assign data_wt    = is_sw;
    assign data_vaddr = res;
    assign data_wdata = rt_val;

    assign wb_valid = (state == S_WB);
    assign wb_pc    = pc;
    assign wb_wnum  = wnum_q;
    assign wb_wdata = res;

endmodule

//--- mycpu.sv
`timescale 1ns/1ps

module mycpu import mips_pkg::*; #(
    parameter logic do_addr_translation = 1'b1
) (
    input  logic      clk,
    input  logic      reset,
    output logic      inst_req,
    output logic      inst_wr,
    output word_t     inst_addr,
    output word_t     inst_wdata,
    input  word_t     inst_rdata,
    input  logic      inst_addr_ok,
    input  logic      inst_data_ok,
    output logic      data_req,
    output logic      data_wr,
    output word_t     data_addr,
    output word_t     data_wdata,
    input  word_t     data_rdata,
    input  logic      data_addr_ok,
    input  logic      data_data_ok,
    output word_t     debug_wb_pc,
    output rwen_t     debug_wb_rf_wen,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);
    logic      inst_en, inst_done;
    logic      data_en, data_wt, data_done;
    word_t     inst_vaddr, data_vaddr;
    logic      wb_valid;
    word_t     wb_pc;
    reg_addr_t wb_wnum;
    word_t     wb_wdata;

    // kseg0 and kseg1 fold onto the low 512MB
    function automatic word_t translate(input word_t va);
        word_t pa;
        pa = va;
        case (va[31:28])
            4'h8, 4'ha: pa[31:28] = 4'h0;
            4'h9, 4'hb: pa[31:28] = 4'h1;
            default: ;
        endcase
        return pa;
    endfunction

    mips_core u_mips_core (
        .clk, .reset,
        .inst_en, .inst_vaddr, .inst_done, .inst_rdata,
        .data_en, .data_wt, .data_vaddr, .data_wdata, .data_done, .data_rdata,
        .wb_valid, .wb_pc, .wb_wnum, .wb_wdata
    );

    handshake i_handshake (
        .clk, .reset, .cpu_req(inst_en), .req(inst_req),
        .addr_ok(inst_addr_ok), .data_ok(inst_data_ok), .done(inst_done)
    );

    handshake d_handshake (
        .clk, .reset, .cpu_req(data_en), .req(data_req),
        .addr_ok(data_addr_ok), .data_ok(data_data_ok), .done(data_done)
    );

    // instruction side never writes
    assign inst_wr    = 1'b0;
    assign inst_wdata = '0;
    assign data_wr    = data_wt;

    if (do_addr_translation) begin : g_xlat
        assign inst_addr = translate(inst_vaddr);
        assign data_addr = translate(data_vaddr);
    end else begin : g_pass
        assign inst_addr = inst_vaddr;
        assign data_addr = data_vaddr;
    end

    // pc reads zero between retires
    assign debug_wb_pc       = wb_valid ? wb_pc : '0;
    assign debug_wb_rf_wen   = {4{wb_valid && wb_wnum != '0}};
    assign debug_wb_rf_wnum  = wb_wnum;
    assign debug_wb_rf_wdata = wb_wdata;

endmodule

//--- sram_arbiter.sv
`timescale 1ns/1ps

module sram_arbiter import mips_pkg::*; #(
    parameter logic first_grant = 1'b0
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  inst_req,
    input  logic  inst_wr,
    input  word_t inst_addr,
    input  word_t inst_wdata,
    output word_t inst_rdata,
    output logic  inst_addr_ok,
    output logic  inst_data_ok,
    input  logic  data_req,
    input  logic  data_wr,
    input  word_t data_addr,
    input  word_t data_wdata,
    output word_t data_rdata,
    output logic  data_addr_ok,
    output logic  data_data_ok,
    output logic  mem_req,
    output logic  mem_wr,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok
);
    // port encoding is 0 for inst, 1 for data
    logic busy, owner, last_win;
    logic sel, cur, accept;

    assign sel    = (inst_req && data_req) ? ~last_win : data_req;
    assign cur    = busy ? owner : sel;
    assign accept = mem_req && mem_addr_ok;

    assign mem_req   = !busy && (inst_req || data_req);
    assign mem_wr    = cur ? data_wr    : inst_wr;
    assign mem_addr  = cur ? data_addr  : inst_addr;
    assign mem_wdata = cur ? data_wdata : inst_wdata;

    // losers see no addr_ok and keep holding req
    assign inst_addr_ok = accept && !sel;
    assign data_addr_ok = accept && sel;
    assign inst_data_ok = busy && !owner && mem_data_ok;
    assign data_data_ok = busy && owner && mem_data_ok;
    assign inst_rdata   = mem_rdata;
    assign data_rdata   = mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            owner    <= 1'b0;
            last_win <= ~first_grant;
        end else if (accept) begin
            busy     <= 1'b1;
            owner    <= sel;
            last_win <= sel;
        end else if (busy && mem_data_ok) begin
            busy <= 1'b0;
        end
    end

    // a waiting port keeps its request and address until accepted
    a_inst_held: assert property (@(posedge clk) disable iff (reset)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr));

    a_data_held: assert property (@(posedge clk) disable iff (reset)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr));

    a_no_stray_resp: assert property (@(posedge clk) disable iff (reset)
        mem_data_ok |-> busy);

endmodule

//--- soc_top.sv
`timescale 1ns/1ps

module soc_top import mips_pkg::*; #(
    parameter logic do_addr_translation = 1'b1,
    parameter logic first_grant         = 1'b0
) (
    input  logic      clk,
    input  logic      reset,
    output logic      mem_req,
    output logic      mem_wr,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    input  word_t     mem_rdata,
    input  logic      mem_addr_ok,
    input  logic      mem_data_ok,
    output word_t     debug_wb_pc,
    output rwen_t     debug_wb_rf_wen,
    output reg_addr_t debug_wb_rf_wnum,
    output word_t     debug_wb_rf_wdata
);
    // cpu side of the arbiter
    logic  inst_req, inst_wr, inst_addr_ok, inst_data_ok;
    logic  data_req, data_wr, data_addr_ok, data_data_ok;
    word_t inst_addr, inst_wdata, inst_rdata;
    word_t data_addr, data_wdata, data_rdata;

    mycpu #(
        .do_addr_translation(do_addr_translation)
    ) u_mycpu (
        .clk, .reset,
        .inst_req, .inst_wr, .inst_addr, .inst_wdata, .inst_rdata,
        .inst_addr_ok, .inst_data_ok,
        .data_req, .data_wr, .data_addr, .data_wdata, .data_rdata,
        .data_addr_ok, .data_data_ok,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    sram_arbiter #(
        .first_grant(first_grant)
    ) u_sram_arbiter (
        .clk, .reset,
        .inst_req, .inst_wr, .inst_addr, .inst_wdata, .inst_rdata,
        .inst_addr_ok, .inst_data_ok,
        .data_req, .data_wr, .data_addr, .data_wdata, .data_rdata,
        .data_addr_ok, .data_data_ok,
        .mem_req, .mem_wr, .mem_addr, .mem_wdata, .mem_rdata,
        .mem_addr_ok, .mem_data_ok
    );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker import mips_pkg::*; #(
    parameter int prog_len = 202
) (
    input  logic      clk,
    input  logic      reset,
    input  word_t     prog [prog_len],
    input  logic      mem_req,
    input  logic      mem_wr,
    input  word_t     mem_addr,
    input  word_t     mem_wdata,
    input  logic      mem_addr_ok,
    input  logic      mem_data_ok,
    input  word_t     debug_wb_pc,
    input  rwen_t     debug_wb_rf_wen,
    input  reg_addr_t debug_wb_rf_wnum,
    input  word_t     debug_wb_rf_wdata,
    output logic      done,
    output int        err_count
);
    localparam int N_TESTS  = 6;
    localparam int T_ALU    = 0;
    localparam int T_LDST   = 1;
    localparam int T_BRANCH = 2;
    localparam int T_XLAT   = 3;
    localparam int T_ZERO   = 4;
    localparam int T_ARB    = 5;

    word_t  regs [32];
    word_t  dmem [64];
    word_t  pc;
    int     accepts;
    int     loops;
    logic   outstanding;
    logic   reset_seen = 1'b0;
    int     n_checks [N_TESTS] = '{default: 0};
    int     n_errs [N_TESTS]   = '{default: 0};
    int     total_errs         = 0;
    instr_u ins;

    assign err_count = total_errs;

    // kseg0 and kseg1 drop the top three address bits
    function automatic word_t kseg_phys(input word_t va);
        if (va[31:30] == 2'b10) return {3'b000, va[28:0]};
        return va;
    endfunction

    function automatic word_t fetch_word(input word_t a);
        int idx;
        idx = int'((a - RESET_PC) >> 2);
        if (idx >= 0 && idx < prog_len) return prog[idx];
        return '0;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            T_ALU:    return "alu_writeback";
            T_LDST:   return "load_store";
            T_BRANCH: return "branch_flow";
            T_XLAT:   return "addr_translation";
            T_ZERO:   return "zero_and_nowrite";
            default:  return "reset_arbitration";
        endcase
    endfunction

    task automatic check(input int t, input logic ok, input string msg);
        n_checks[t]++;
        if (!ok) begin
            n_errs[t]++;
            total_errs++;
            $display("CHECK FAILED at %0d ns: %s", $time, msg);
        end
    endtask

    task automatic report;
        int total;
        total = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            $display("test %s: %0d checks, %0d errors", test_name(t), n_checks[t], n_errs[t]);
            total += n_checks[t];
        end
        $display("total: %0d checks, %0d errors", total, total_errs);
    endtask

    task automatic retire;
        word_t     simm;
        word_t     pa;
        word_t     next_pc;
        word_t     exp_val;
        reg_addr_t exp_dest;
        logic      is_mem;
        int        cat;
        ins      = fetch_word(pc);
        simm     = {{16{ins.i.imm[15]}}, ins.i.imm};
        pa       = kseg_phys(regs[ins.i.rs] + simm);
        next_pc  = pc + 32'd4;
        exp_val  = '0;
        exp_dest = '0;
        is_mem   = 1'b0;
        case (ins.i.opcode)
            OP_SPECIAL: if (ins.r.funct == FN_ADDU) begin
                exp_dest = ins.r.rd;
                exp_val  = regs[ins.r.rs] + regs[ins.r.rt];
            end
            OP_ADDIU: begin
                exp_dest = ins.i.rt;
                exp_val  = regs[ins.i.rs] + simm;
            end
            OP_LUI: begin
                exp_dest = ins.i.rt;
                exp_val  = {ins.i.imm, 16'h0000};
            end
            OP_LW: begin
                is_mem   = 1'b1;
                exp_dest = ins.i.rt;
                exp_val  = dmem[pa[7:2]];
            end
            OP_SW: begin
                is_mem = 1'b1;
                dmem[pa[7:2]] = regs[ins.i.rt];
            end
            OP_BEQ: if (regs[ins.i.rs] == regs[ins.i.rt]) next_pc = pc + 32'd4 + (simm << 2);
            default: ;
        endcase
        cat = (exp_dest == '0) ? T_ZERO : ((ins.i.opcode == OP_LW) ? T_LDST : T_ALU);
        check(T_BRANCH, debug_wb_pc == pc,
              $sformatf("retired pc %h, expected %h", debug_wb_pc, pc));
        check(T_ARB, accepts == (is_mem ? 2 : 1),
              $sformatf("pc %h took %0d bus transactions", pc, accepts));
        check(cat, debug_wb_rf_wnum == exp_dest,
              $sformatf("pc %h wnum %0d, expected %0d", pc, debug_wb_rf_wnum, exp_dest));
        check(cat, debug_wb_rf_wen == ((exp_dest != '0) ? 4'hf : 4'h0),
              $sformatf("pc %h rf_wen %h", pc, debug_wb_rf_wen));
        if (exp_dest != '0) begin
            check(cat, debug_wb_rf_wdata == exp_val,
                  $sformatf("pc %h wdata %h, expected %h", pc, debug_wb_rf_wdata, exp_val));
            regs[exp_dest] = exp_val;
        end
        // two passes through the self-loop end the run
        if (pc == RESET_PC + 32'((prog_len - 1) * 4)) begin
            loops++;
            if (loops == 2) begin
                done <= 1'b1;
                report();
            end
        end
        pc = next_pc;
        accepts = 0;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (reset_seen) begin
                check(T_ARB, !mem_req, "mem_req high during reset");
                check(T_ZERO, debug_wb_rf_wen == 4'h0, "rf_wen high during reset");
            end
            reset_seen <= 1'b1;
            done <= 1'b0;
            pc = RESET_PC;
            accepts = 0;
            loops = 0;
            outstanding = 1'b0;
            for (int i = 0; i < 32; i++) regs[i] = '0;
            for (int i = 0; i < 64; i++) dmem[i] = '0;
        end else if (!done) begin
            if (mem_data_ok) begin
                check(T_ARB, outstanding, "memory response without an accepted request");
                outstanding = 1'b0;
            end
            if (mem_req && mem_addr_ok) begin
                check(T_ARB, !outstanding, "request accepted while another is outstanding");
                outstanding = 1'b1;
                ins = fetch_word(pc);
                if (accepts == 0) begin
                    check(T_XLAT, mem_addr == kseg_phys(pc) && !mem_wr,
                          $sformatf("fetch at %h, expected %h", mem_addr, kseg_phys(pc)));
                end else begin
                    check(T_XLAT, mem_addr == kseg_phys(regs[ins.i.rs] +
                          {{16{ins.i.imm[15]}}, ins.i.imm}),
                          $sformatf("data access at %h for pc %h", mem_addr, pc));
                    check(T_LDST, mem_wr == (ins.i.opcode == OP_SW),
                          $sformatf("write flag %b for pc %h", mem_wr, pc));
                    if (ins.i.opcode == OP_SW) begin
                        check(T_LDST, mem_wdata == regs[ins.i.rt],
                              $sformatf("store data %h, expected %h", mem_wdata,
                                        regs[ins.i.rt]));
                    end
                end
                accepts++;
            end
            if (debug_wb_pc != '0) retire();
        end
    end

endmodule

//--- tb_top.sv
`timescale 1ns/1ps

module tb_top import mips_pkg::*; ();

    localparam int    PROG_LEN       = 202;
    localparam int    DATA_WORDS     = 64;
    localparam int    RESET_CYCLES   = 8;
    localparam int    MAX_TXN_CYCLES = 10;
    // two bus transactions per instruction at worst, plus margin
    localparam int    TIMEOUT_CYCLES = PROG_LEN * 2 * MAX_TXN_CYCLES + 1960;
    localparam word_t PROG_BASE      = 32'h1fc0_0000;

    logic      clk;
    logic      reset       = 1'b1;
    logic      mem_req, mem_wr;
    word_t     mem_addr, mem_wdata;
    word_t     mem_rdata   = '0;
    logic      mem_addr_ok = 1'b0;
    logic      mem_data_ok = 1'b0;
    word_t     debug_wb_pc, debug_wb_rf_wdata;
    rwen_t     debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;

    word_t prog [PROG_LEN];
    word_t dmem [DATA_WORDS];
    word_t gen_state = 32'd92;
    word_t lat_state = 32'd92;
    logic  pending   = 1'b0;
    int    addr_wait = 0;
    int    data_wait = 0;
    word_t acc_addr  = '0;
    int    cycles    = 0;
    logic  chk_done;
    int    chk_errors;

    function automatic word_t xorshift(input word_t x);
        word_t y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_addu(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, FN_ADDU};
    endfunction

    function automatic reg_addr_t src_reg(input logic [2:0] r);
        return {2'b00, r};
    endfunction

    // r1 stays the data base, picking it turns into a write to r0
    function automatic reg_addr_t dest_reg(input logic [2:0] r);
        return (r == 3'd1) ? 5'd0 : {2'b00, r};
    endfunction

    task automatic build_program;
        word_t     r;
        int        kind;
        int        off;
        reg_addr_t b;
        prog[0] = enc_i(OP_LUI, 5'd0, 5'd1, 16'ha000);
        for (int k = 1; k < PROG_LEN - 1; k++) begin
            gen_state = xorshift(gen_state);
            r = gen_state;
            kind = int'(r[31:29]) % 6;
            case (kind)
                0: prog[k] = enc_i(OP_ADDIU, src_reg(r[5:3]), dest_reg(r[2:0]), r[27:12]);
                1: prog[k] = enc_addu(src_reg(r[5:3]), src_reg(r[8:6]), dest_reg(r[2:0]));
                2: prog[k] = enc_i(OP_LUI, 5'd0, dest_reg(r[2:0]), r[27:12]);
                3: prog[k] = enc_i(OP_LW, 5'd1, dest_reg(r[2:0]), {8'h00, r[17:12], 2'b00});
                4: prog[k] = enc_i(OP_SW, 5'd1, src_reg(r[5:3]), {8'h00, r[17:12], 2'b00});
                default: begin
                    // forward only, never past the final loop
                    off = int'(r[10:9]);
                    if (off > PROG_LEN - 2 - k) off = PROG_LEN - 2 - k;
                    b = r[11] ? src_reg(r[5:3]) : src_reg(r[8:6]);
                    prog[k] = enc_i(OP_BEQ, src_reg(r[5:3]), b, 16'(off));
                end
            endcase
        end
        prog[PROG_LEN - 1] = enc_i(OP_BEQ, 5'd0, 5'd0, 16'hffff);
    endtask

    function automatic word_t mem_read(input word_t a);
        int idx;
        idx = int'((a - PROG_BASE) >> 2);
        if (a >= PROG_BASE && idx < PROG_LEN) return prog[idx];
        if (a < 32'd256) return dmem[a[7:2]];
        // unmapped space
        return ~a;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // memory with random accept and response delays
    always @(posedge clk) begin
        if (reset) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            pending = 1'b0;
            addr_wait = 0;
            for (int i = 0; i < DATA_WORDS; i++) dmem[i] = '0;
        end else begin
            mem_data_ok <= 1'b0;
            if (mem_addr_ok) begin
                mem_addr_ok <= 1'b0;
                if (mem_req) begin
                    acc_addr = mem_addr;
                    if (mem_wr && mem_addr < 32'd256) dmem[mem_addr[7:2]] = mem_wdata;
                    lat_state = xorshift(lat_state);
                    data_wait = int'(lat_state[1:0]);
                    addr_wait = int'(lat_state[3:2]);
                    pending = 1'b1;
                end
            end else if (mem_req && !pending) begin
                if (addr_wait == 0) mem_addr_ok <= 1'b1;
                else addr_wait--;
            end
            if (pending) begin
                if (data_wait == 0) begin
                    mem_data_ok <= 1'b1;
                    mem_rdata <= mem_read(acc_addr);
                    pending = 1'b0;
                end else begin
                    data_wait--;
                end
            end
        end
    end

    soc_top #(
        .do_addr_translation(1'b1),
        .first_grant(1'b0)
    ) u_soc_top (
        .clk, .reset,
        .mem_req, .mem_wr, .mem_addr, .mem_wdata, .mem_rdata, .mem_addr_ok, .mem_data_ok,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    tb_checker #(
        .prog_len(PROG_LEN)
    ) u_tb_checker (
        .clk, .reset, .prog,
        .mem_req, .mem_wr, .mem_addr, .mem_wdata, .mem_addr_ok, .mem_data_ok,
        .debug_wb_pc, .debug_wb_rf_wen, .debug_wb_rf_wnum, .debug_wb_rf_wdata,
        .done(chk_done), .err_count(chk_errors)
    );

    initial begin
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (!chk_done && cycles < TIMEOUT_CYCLES) @(posedge clk);
        if (!chk_done) begin
            $display("timeout: final loop not reached after %0d cycles", cycles);
        end
        if (chk_done && chk_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- flist.f
mips_pkg.sv
handshake.sv
mips_core.sv
mycpu.sv
sram_arbiter.sv
soc_top.sv
tb_checker.sv
tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_top -f flist.f -o tb_sim
if ! ./obj_dir/tb_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation aborted"
    exit 1
fi
cat sim.log
if grep -q "Errors found" sim.log; then
    exit 1
fi
